// ==== source/socket_config.svh ====
/*
 * Socket configuration
 * Core count, bus widths, request FIFO depth and the limit
 * on outstanding memory reads
 */

`ifndef SOCKET_CONFIG_SVH
`define SOCKET_CONFIG_SVH

// Number of load-summing cores in the socket
`define SOCKET_NUM_CORES   4

// Memory word address and data word widths
`define SOCKET_ADDR_W      16
`define SOCKET_WORD_W      32

// Tag holds a core index
`define SOCKET_TAG_W       2

// Shared request FIFO entries
`define SOCKET_BUF_DEPTH   4

// Reads allowed in flight at the memory port
`define SOCKET_MAX_PENDING 2

`endif

// ==== source/socket_pkg.sv ====
/*
 * Socket package
 * Shared word, address and tag types, the core FSM states
 * and the configuration register map
 */

`include "socket_config.svh"

package socket_pkg;

    // Bus payload types
    typedef logic [`SOCKET_ADDR_W-1:0] addr_t;
    typedef logic [`SOCKET_WORD_W-1:0] word_t;
    typedef logic [`SOCKET_TAG_W-1:0]  tag_t;

    // Core sequencer states
    typedef enum logic [1:0] {
        CORE_IDLE  = 2'd0,
        CORE_ISSUE = 2'd1,
        CORE_DRAIN = 2'd2,
        CORE_DONE  = 2'd3
    } core_state_e;

    // Configuration register addresses
    typedef enum logic [1:0] {
        DCR_BASE  = 2'd0,
        DCR_COUNT = 2'd1
    } dcr_addr_e;

endpackage

// ==== source/socket_core.sv ====
/*
 * Load-summing core
 * Decodes the shared configuration bus, issues reads over its
 * slice of the block and accumulates the returned words
 */

`timescale 1ns/1ps

`include "socket_config.svh"

module socket_core #(
    parameter int CORE_ID = 0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  dcr_wr_valid,
    input  socket_pkg::dcr_addr_e dcr_wr_addr,
    input  socket_pkg::word_t     dcr_wr_data,
    input  logic                  start,
    input  logic                  grant,
    input  logic                  rsp_valid,
    input  socket_pkg::word_t     rsp_data,
    output logic                  req,
    output socket_pkg::addr_t     req_addr,
    output logic                  done,
    output socket_pkg::word_t     result_sum,
    output logic                  busy
);

    socket_pkg::core_state_e state_q, state_d;

    socket_pkg::addr_t base_q;
    socket_pkg::addr_t count_q;
    socket_pkg::addr_t issue_cnt_q;
    socket_pkg::addr_t rsp_cnt_q;
    socket_pkg::word_t acc_q;

    logic idle;
    logic start_ok;
    logic issue_last;
    logic rsp_last;

    assign idle       = (state_q == socket_pkg::CORE_IDLE);
    assign start_ok   = start && idle;
    assign issue_last = grant && ((issue_cnt_q + 1'b1) == count_q);
    assign rsp_last   = rsp_valid && ((rsp_cnt_q + 1'b1) == count_q);

    // Config registers only change between runs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            base_q  <= '0;
            count_q <= '0;
        end else if (dcr_wr_valid && idle) begin
            case (dcr_wr_addr)
                socket_pkg::DCR_BASE:  base_q  <= socket_pkg::addr_t'(dcr_wr_data);
                socket_pkg::DCR_COUNT: count_q <= socket_pkg::addr_t'(dcr_wr_data);
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Sequencer FSM
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            socket_pkg::CORE_IDLE: begin
                if (start) state_d = socket_pkg::CORE_ISSUE;
            end
            socket_pkg::CORE_ISSUE: begin
                // Empty slice finishes right away
                if (count_q == '0) state_d = socket_pkg::CORE_DONE;
                else if (issue_last) state_d = socket_pkg::CORE_DRAIN;
            end
            socket_pkg::CORE_DRAIN: begin
                if (rsp_last) state_d = socket_pkg::CORE_DONE;
            end
            default: state_d = socket_pkg::CORE_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= socket_pkg::CORE_IDLE;
            issue_cnt_q <= '0;
            rsp_cnt_q   <= '0;
            acc_q       <= '0;
        end else begin
            state_q <= state_d;
            if (start_ok) begin
                issue_cnt_q <= '0;
                rsp_cnt_q   <= '0;
                acc_q       <= '0;
            end else begin
                if (grant) issue_cnt_q <= issue_cnt_q + 1'b1;
                if (rsp_valid) begin
                    rsp_cnt_q <= rsp_cnt_q + 1'b1;
                    acc_q     <= acc_q + rsp_data;
                end
            end
        end
    end

    // Slice for core i starts at base + i * count
    assign req      = (state_q == socket_pkg::CORE_ISSUE) && (issue_cnt_q != count_q);
    assign req_addr = base_q + socket_pkg::addr_t'(CORE_ID) * count_q + issue_cnt_q;

    assign done       = (state_q == socket_pkg::CORE_DONE);
    assign busy       = !idle;
    assign result_sum = acc_q;

endmodule

// ==== source/mem_req_buffer.sv ====
/*
 * Memory request buffer
 * Round-robin arbiter over the core requests in front of a
 * small address and tag FIFO
 */

`timescale 1ns/1ps

`include "socket_config.svh"

module mem_req_buffer (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic              [`SOCKET_NUM_CORES-1:0]    req,
    input  socket_pkg::addr_t [`SOCKET_NUM_CORES-1:0]    req_addr,
    input  logic                                         pop,
    output logic              [`SOCKET_NUM_CORES-1:0]    grant,
    output logic                                         not_empty,
    output socket_pkg::addr_t                            head_addr,
    output socket_pkg::tag_t                             head_tag
);

    localparam int NUM   = `SOCKET_NUM_CORES;
    localparam int DEPTH = `SOCKET_BUF_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    socket_pkg::addr_t addr_mem [DEPTH];
    socket_pkg::tag_t  tag_mem  [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    socket_pkg::tag_t rr_ptr_q;
    socket_pkg::tag_t win_idx;
    logic             arb_hit;
    logic             fifo_space;
    logic             push;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // A pop in the same cycle frees one entry
    assign fifo_space = (count_q != CNT_W'(DEPTH)) || pop;

    ////////////////////////////////////////////////////////////
    // Round-robin pick, starting after the last winner
    ////////////////////////////////////////////////////////////

    always_comb begin
        int cand;
        grant   = '0;
        win_idx = '0;
        arb_hit = 1'b0;
        for (int k = 0; k < NUM; k++) begin
            cand = (int'(rr_ptr_q) + k) % NUM;
            if (!arb_hit && req[cand]) begin
                arb_hit = 1'b1;
                win_idx = socket_pkg::tag_t'(cand);
            end
        end
        if (arb_hit && fifo_space) grant[win_idx] = 1'b1;
    end

    assign push = arb_hit && fifo_space;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rr_ptr_q <= '0;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                rr_ptr_q <= socket_pkg::tag_t'((int'(win_idx) + 1) % NUM);
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) rd_ptr_q <= next_ptr(rd_ptr_q);
            if (push && !pop) count_q <= count_q + 1'b1;
            else if (pop && !push) count_q <= count_q - 1'b1;
        end
    end

    // FIFO storage
    always_ff @(posedge clk) begin
        if (push) begin
            addr_mem[wr_ptr_q] <= req_addr[win_idx];
            tag_mem[wr_ptr_q]  <= win_idx;
        end
    end

    assign not_empty = (count_q != '0);
    assign head_addr = addr_mem[rd_ptr_q];
    assign head_tag  = tag_mem[rd_ptr_q];

endmodule

// ==== source/mem_gateway.sv ====
/*
 * Memory gateway
 * Drains the request FIFO under a pending-read limit and steers
 * each tagged response back to its core
 */

`timescale 1ns/1ps

`include "socket_config.svh"

module mem_gateway (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               not_empty,
    input  socket_pkg::addr_t                  head_addr,
    input  socket_pkg::tag_t                   head_tag,
    input  logic                               mem_rsp_valid,
    input  socket_pkg::tag_t                   mem_rsp_tag,
    input  socket_pkg::word_t                  mem_rsp_data,
    output logic                               pop,
    output logic                               mem_req_valid,
    output socket_pkg::addr_t                  mem_req_addr,
    output socket_pkg::tag_t                   mem_req_tag,
    output logic [`SOCKET_NUM_CORES-1:0]       rsp_valid,
    output socket_pkg::word_t                  rsp_data
);

    localparam int MAX_PEND = `SOCKET_MAX_PENDING;
    localparam int PEND_W   = $clog2(MAX_PEND + 1);

    logic [PEND_W-1:0]            pend_q;
    logic [`SOCKET_NUM_CORES-1:0] rsp_sel;

    // Counted at pop so the limit covers the request register too
    assign pop = not_empty && (pend_q < PEND_W'(MAX_PEND));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_q        <= '0;
            mem_req_valid <= 1'b0;
            rsp_valid     <= '0;
        end else begin
            if (pop && !mem_rsp_valid) pend_q <= pend_q + 1'b1;
            else if (!pop && mem_rsp_valid) pend_q <= pend_q - 1'b1;
            mem_req_valid <= pop;
            rsp_valid     <= rsp_sel;
        end
    end

    // Tag to one-hot core select
    always_comb begin
        for (int i = 0; i < `SOCKET_NUM_CORES; i++) begin
            rsp_sel[i] = mem_rsp_valid && (mem_rsp_tag == socket_pkg::tag_t'(i));
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            mem_req_addr <= head_addr;
            mem_req_tag  <= head_tag;
        end
        if (mem_rsp_valid) rsp_data <= mem_rsp_data;
    end

endmodule

// ==== source/socket_top.sv ====
/*
 * Compute socket top level
 * Cores share one configuration bus and one memory path
 * through the request buffer and the gateway
 */

`timescale 1ns/1ps

`include "socket_config.svh"

module socket_top (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      dcr_wr_valid,
    input  socket_pkg::dcr_addr_e                     dcr_wr_addr,
    input  socket_pkg::word_t                         dcr_wr_data,
    input  logic                                      start,
    input  logic                                      mem_rsp_valid,
    input  socket_pkg::tag_t                          mem_rsp_tag,
    input  socket_pkg::word_t                         mem_rsp_data,
    output logic                                      mem_req_valid,
    output socket_pkg::addr_t                         mem_req_addr,
    output socket_pkg::tag_t                          mem_req_tag,
    output logic              [`SOCKET_NUM_CORES-1:0] done,
    output socket_pkg::word_t [`SOCKET_NUM_CORES-1:0] result_sum,
    output logic                                      busy
);

    logic              [`SOCKET_NUM_CORES-1:0] core_req;
    socket_pkg::addr_t [`SOCKET_NUM_CORES-1:0] core_req_addr;
    logic              [`SOCKET_NUM_CORES-1:0] core_grant;
    logic              [`SOCKET_NUM_CORES-1:0] core_rsp_valid;
    logic              [`SOCKET_NUM_CORES-1:0] core_busy;
    socket_pkg::word_t                         rsp_data;

    logic              buf_not_empty;
    logic              buf_pop;
    socket_pkg::addr_t buf_head_addr;
    socket_pkg::tag_t  buf_head_tag;

    ////////////////////////////////////////////////////////////
    // Cores
    ////////////////////////////////////////////////////////////

    for (genvar i = 0; i < `SOCKET_NUM_CORES; i++) begin : g_core
        socket_core #(
            .CORE_ID (i)
        ) core (
            .clk          (clk),
            .rst_n        (rst_n),
            .dcr_wr_valid (dcr_wr_valid),
            .dcr_wr_addr  (dcr_wr_addr),
            .dcr_wr_data  (dcr_wr_data),
            .start        (start),
            .grant        (core_grant[i]),
            .rsp_valid    (core_rsp_valid[i]),
            .rsp_data     (rsp_data),
            .req          (core_req[i]),
            .req_addr     (core_req_addr[i]),
            .done         (done[i]),
            .result_sum   (result_sum[i]),
            .busy         (core_busy[i])
        );
    end

    // Shared memory path
    mem_req_buffer req_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (core_req),
        .req_addr  (core_req_addr),
        .pop       (buf_pop),
        .grant     (core_grant),
        .not_empty (buf_not_empty),
        .head_addr (buf_head_addr),
        .head_tag  (buf_head_tag)
    );

    mem_gateway gateway (
        .clk           (clk),
        .rst_n         (rst_n),
        .not_empty     (buf_not_empty),
        .head_addr     (buf_head_addr),
        .head_tag      (buf_head_tag),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_tag   (mem_rsp_tag),
        .mem_rsp_data  (mem_rsp_data),
        .pop           (buf_pop),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_tag   (mem_req_tag),
        .rsp_valid     (core_rsp_valid),
        .rsp_data      (rsp_data)
    );

    assign busy = |core_busy;

endmodule

// ==== test/socket_chk.sv ====
/*
 * Request buffer checker
 * Concurrent assertions on the round-robin grant vector
 */

`timescale 1ns/1ps

`include "socket_config.svh"

module socket_chk #(
    parameter int CNT_W = $clog2(`SOCKET_BUF_DEPTH + 1)
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [`SOCKET_NUM_CORES-1:0] req,
    input  logic [`SOCKET_NUM_CORES-1:0] grant,
    input  logic                         pop,
    input  logic [CNT_W-1:0]             fifo_count
);

    logic fifo_full;

    assign fifo_full = (fifo_count == CNT_W'(`SOCKET_BUF_DEPTH));

    a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(grant))
        else $error("grant has more than one bit set");

    a_grant_to_req: assert property (@(posedge clk) disable iff (!rst_n)
        (grant & ~req) == '0)
        else $error("grant given to a core that does not request");

    // A pop in the same cycle makes room for one push
    a_no_grant_full: assert property (@(posedge clk) disable iff (!rst_n)
        (fifo_full && !pop) |-> (grant == '0))
        else $error("grant given while the FIFO is full");

    a_grant_reset: assert property (@(posedge clk)
        (!rst_n || $rose(rst_n)) |-> (grant == '0))
        else $error("grant high in or right after reset");

endmodule

// ==== test/socket_tb.sv ====
/*
 * Socket testbench
 * Drives the configuration bus and start, models an in-order
 * memory with random latency and checks each core's sum
 */

`timescale 1ns/1ps

`include "socket_config.svh"

module socket_tb;

    localparam int NUM         = `SOCKET_NUM_CORES;
    localparam int NUM_RUNS    = 6;
    localparam int MAX_COUNT   = 12;
    localparam int WORD_CYCLES = 10;
    localparam int MARGIN      = 1000;

    logic                               clk;
    logic                               rst_n;
    logic                               dcr_wr_valid;
    socket_pkg::dcr_addr_e              dcr_wr_addr;
    socket_pkg::word_t                  dcr_wr_data;
    logic                               start;
    logic                               mem_rsp_valid = 1'b0;
    socket_pkg::tag_t                   mem_rsp_tag   = '0;
    socket_pkg::word_t                  mem_rsp_data  = '0;
    logic                               mem_req_valid;
    socket_pkg::addr_t                  mem_req_addr;
    socket_pkg::tag_t                   mem_req_tag;
    logic              [NUM-1:0]        done;
    socket_pkg::word_t [NUM-1:0]        result_sum;
    logic                               busy;

    // Settings of the run in progress
    int run_base;
    int run_count;
    int max_delay;
    int done_cnt [NUM];
    int done_total;
    int cyc;

    // Reads waiting in the memory model
    socket_pkg::addr_t rq_addr [$];
    socket_pkg::tag_t  rq_tag  [$];
    int                rq_due  [$];

    socket_top UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .dcr_wr_valid  (dcr_wr_valid),
        .dcr_wr_addr   (dcr_wr_addr),
        .dcr_wr_data   (dcr_wr_data),
        .start         (start),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_tag   (mem_rsp_tag),
        .mem_rsp_data  (mem_rsp_data),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_tag   (mem_req_tag),
        .done          (done),
        .result_sum    (result_sum),
        .busy          (busy)
    );

    bind mem_req_buffer socket_chk buf_chk (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .grant      (grant),
        .pop        (pop),
        .fifo_count (count_q)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic socket_pkg::word_t mem_word(input socket_pkg::addr_t addr);
        return {addr ^ 16'hA5C3, ~addr} ^ 32'h1357_9BDF;
    endfunction

    // Wrapping sum over the slice base + core * count
    function automatic socket_pkg::word_t ref_sum(input int base, input int count,
                                                  input int core);
        socket_pkg::word_t sum;
        socket_pkg::addr_t addr;
        sum = '0;
        for (int j = 0; j < count; j++) begin
            addr = socket_pkg::addr_t'(base + core * count + j);
            sum  = sum + mem_word(addr);
        end
        return sum;
    endfunction

    function automatic int owner_of(input socket_pkg::addr_t addr);
        socket_pkg::addr_t offset;
        offset = addr - socket_pkg::addr_t'(run_base);
        return int'(offset) / run_count;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped after an error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL time=%0t signal=%s got=0x%08h expected=0x%08h",
                                $time, name, got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////////////////////////

    task automatic write_dcr(input socket_pkg::dcr_addr_e addr, input int data);
        @(posedge clk);
        dcr_wr_valid <= 1'b1;
        dcr_wr_addr  <= addr;
        dcr_wr_data  <= socket_pkg::word_t'(data);
        @(posedge clk);
        dcr_wr_valid <= 1'b0;
    endtask

    task automatic configure(input int base, input int count);
        write_dcr(socket_pkg::DCR_BASE, base);
        write_dcr(socket_pkg::DCR_COUNT, count);
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic start_run(input int base, input int count);
        run_base   = base;
        run_count  = count;
        done_total = 0;
        foreach (done_cnt[i]) done_cnt[i] = 0;
        pulse_start();
        // Cores leave idle one cycle after start
        @(posedge clk);
        check_val("busy", 32'(busy), 32'd1);
    endtask

    task automatic finish_run();
        wait (done_total >= NUM);
        @(posedge clk);
        check_val("busy", 32'(busy), 32'd0);
        repeat (4) @(posedge clk);
        for (int i = 0; i < NUM; i++) begin
            check_val($sformatf("done count of core %0d", i), done_cnt[i], 32'd1);
        end
    endtask

    task automatic do_run(input int base, input int count);
        configure(base, count);
        start_run(base, count);
        finish_run();
    endtask

    // In-order memory with a random delay per read
    always @(posedge clk) begin
        int due;
        mem_rsp_valid <= 1'b0;
        if (mem_req_valid === 1'b1) begin
            if (run_count == 0) begin
                abort_run("A memory request appeared in a run with count zero");
            end else begin
                check_val("mem_req_tag", 32'(mem_req_tag), 32'(owner_of(mem_req_addr)));
            end
            due = cyc + int'($urandom_range(max_delay, 0));
            rq_addr.push_back(mem_req_addr);
            rq_tag.push_back(mem_req_tag);
            rq_due.push_back(due);
            if (rq_addr.size() > `SOCKET_MAX_PENDING) begin
                abort_run("More reads are outstanding than the pending limit allows");
            end
        end
        if (rq_addr.size() != 0 && rq_due[0] <= cyc) begin
            mem_rsp_valid <= 1'b1;
            mem_rsp_tag   <= rq_tag.pop_front();
            mem_rsp_data  <= mem_word(rq_addr.pop_front());
            void'(rq_due.pop_front());
        end
        cyc++;
    end

    // Compare each finished core against the reference
    always @(posedge clk) begin
        for (int i = 0; i < NUM; i++) begin
            if (done[i] === 1'b1) begin
                done_cnt[i]++;
                done_total++;
                check_val($sformatf("result_sum[%0d]", i), result_sum[i],
                          ref_sum(run_base, run_count, i));
            end
        end
    end

    initial begin
        repeat (NUM_RUNS * NUM * MAX_COUNT * WORD_CYCLES + MARGIN) @(posedge clk);
        abort_run("Timeout: the runs did not finish in the expected time");
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(77));
        rst_n        <= 1'b0;
        dcr_wr_valid <= 1'b0;
        dcr_wr_addr  <= socket_pkg::DCR_BASE;
        dcr_wr_data  <= '0;
        start        <= 1'b0;
        run_count    = 0;
        max_delay    = 5;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_val("busy", 32'(busy), 32'd0);
        check_val("mem_req_valid", 32'(mem_req_valid), 32'd0);
        check_val("done", 32'(done), 32'd0);

        do_run(16'h0100, 8);

        // Slow memory fills the FIFO and hits the pending limit
        max_delay = 15;
        do_run(16'h2000, 12);
        max_delay = 5;

        do_run(16'h0300, 0);

        // Writes and start during a run are dropped
        configure(16'h0400, 8);
        start_run(16'h0400, 8);
        configure(16'h0800, 5);
        pulse_start();
        finish_run();

        // Registers still hold the first settings
        start_run(16'h0400, 8);
        finish_run();
        do_run(16'h0800, 5);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+source
source/socket_pkg.sv
source/socket_core.sv
source/mem_req_buffer.sv
source/mem_gateway.sv
source/socket_top.sv
test/socket_chk.sv
test/socket_tb.sv

// ==== Makefile ====
# Verilator build and run for the compute socket testbench

VERILATOR ?= verilator
TOP       ?= socket_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

FAIL_MSG  := *** TEST FAILED ***
PASS_MSG  := *** TEST PASSED ***
SOURCES   := $(wildcard source/*.sv source/*.svh test/*.sv)
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -F -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -F -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not pass"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
